//--- rv_decode.f
+incdir+source
source/rv_pkg.sv
source/inst_decoder.sv
source/datapath_controller.sv
source/hazard_unit.sv
source/register_file.sv
source/branch_unit.sv
source/stage_id.sv
testbench/stage_id_tb.sv

//--- source/branch_unit.sv
module branch_unit (
    input  rv_pkg::data_t      i_data_a,   // Forwarded rs1
    input  rv_pkg::data_t      i_data_b,   // Forwarded rs2
    input  rv_pkg::inst_addr_t i_pc,
    input  rv_pkg::data_t      i_imm,
    input  rv_pkg::pc_sel_t    i_pc_sel,
    output logic               o_equal,
    output logic               o_less_signed,
    output logic               o_less_unsigned,
    output rv_pkg::inst_addr_t o_pc_next
);
    import rv_pkg::*;

    inst_addr_t pc_plus4;
    inst_addr_t pc_target;   // PC relative target, JAL and branches
    inst_addr_t jalr_target;

    // ---------------------------------------
    // Compare
    // ---------------------------------------
    assign o_equal         = (i_data_a == i_data_b);
    assign o_less_signed   = ($signed(i_data_a) < $signed(i_data_b));
    assign o_less_unsigned = (i_data_a < i_data_b);

    // ---------------------------------------
    // Next PC
    // ---------------------------------------
    assign pc_plus4    = i_pc + 32'd4;
    assign pc_target   = i_pc + i_imm;
    assign jalr_target = (i_data_a + i_imm) & ~32'd1;  // Bit 0 cleared

    always_comb begin
        case (i_pc_sel)
            PC_BRANCH: o_pc_next = pc_target;
            PC_JALR:   o_pc_next = jalr_target;
            default:   o_pc_next = pc_plus4;
        endcase
    end

endmodule

//--- source/datapath_controller.sv
module datapath_controller (
    input  rv_pkg::op_code_t       i_op,
    input  logic [2:0]             i_funct3,
    input  logic                   i_funct7_bit5,
    input  logic                   i_is_illegal,
    input  logic                   i_equal,          // rs1 == rs2
    input  logic                   i_less_signed,    // rs1 < rs2, signed
    input  logic                   i_less_unsigned,  // rs1 < rs2, unsigned
    output logic                   o_reg_wr_enable,
    output logic                   o_mem_wr_enable,
    output rv_pkg::wr_data_sel_t   o_reg_wr_data_sel,
    output rv_pkg::operand_a_sel_t o_operand_a_sel,
    output rv_pkg::operand_b_sel_t o_operand_b_sel,
    output rv_pkg::alu_op_t        o_alu_op,
    output rv_pkg::pc_sel_t        o_pc_sel
);
    import rv_pkg::*;

    logic br_taken;

    // funct3 to ALU op, alt is funct7 bit 5 where it applies
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic sub_en,
                                                input logic sra_en);
        alu_op_t op;
        case (f3)
            3'b000:  op = sub_en ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = sra_en ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // Branch condition by funct3
    always_comb begin
        case (i_funct3)
            3'b000:  br_taken = i_equal;          // BEQ
            3'b001:  br_taken = !i_equal;         // BNE
            3'b100:  br_taken = i_less_signed;    // BLT
            3'b101:  br_taken = !i_less_signed;   // BGE
            3'b110:  br_taken = i_less_unsigned;  // BLTU
            3'b111:  br_taken = !i_less_unsigned; // BGEU
            default: br_taken = 1'b0;             // Reserved, falls through
        endcase
    end

    always_comb begin
        // Defaults give a harmless no-write word
        o_reg_wr_enable   = 1'b0;
        o_mem_wr_enable   = 1'b0;
        o_reg_wr_data_sel = WR_ALU;
        o_operand_a_sel   = A_REG;
        o_operand_b_sel   = B_REG;
        o_alu_op          = ADD;
        o_pc_sel          = PC_PLUS4;
        if (!i_is_illegal) begin
            case (i_op)
                OP_LUI: begin
                    o_reg_wr_enable = 1'b1;
                    o_operand_a_sel = A_ZERO;  // 0 + imm
                    o_operand_b_sel = B_IMM;
                end
                OP_AUIPC: begin
                    o_reg_wr_enable = 1'b1;
                    o_operand_a_sel = A_PC;
                    o_operand_b_sel = B_IMM;
                end
                OP_JAL: begin
                    o_reg_wr_enable   = 1'b1;
                    o_reg_wr_data_sel = WR_PC4;  // Link address
                    o_pc_sel          = PC_BRANCH;
                end
                OP_JALR: begin
                    o_reg_wr_enable   = 1'b1;
                    o_reg_wr_data_sel = WR_PC4;
                    o_pc_sel          = PC_JALR;
                end
                OP_BRANCH: o_pc_sel = br_taken ? PC_BRANCH : PC_PLUS4;
                OP_LOAD: begin
                    o_reg_wr_enable   = 1'b1;
                    o_reg_wr_data_sel = WR_MEM;
                    o_operand_b_sel   = B_IMM;   // Address = rs1 + imm
                end
                OP_STORE: begin
                    o_mem_wr_enable = 1'b1;
                    o_operand_b_sel = B_IMM;
                end
                OP_IMM: begin
                    o_reg_wr_enable = 1'b1;
                    o_operand_b_sel = B_IMM;
                    // No SUBI, bit 30 is part of the immediate there
                    o_alu_op = alu_from_funct3(i_funct3, 1'b0, i_funct7_bit5);
                end
                OP_REG: begin
                    o_reg_wr_enable = 1'b1;
                    o_alu_op = alu_from_funct3(i_funct3, i_funct7_bit5, i_funct7_bit5);
                end
                default: o_pc_sel = PC_PLUS4;
            endcase
        end
    end

endmodule

//--- source/hazard_unit.sv
module hazard_unit (
    input  rv_pkg::reg_addr_t    i_rs1,
    input  rv_pkg::reg_addr_t    i_rs2,
    input  rv_pkg::reg_addr_t    i_ex_reg_wr_addr,
    input  logic                 i_ex_reg_wr_enable,
    input  rv_pkg::wr_data_sel_t i_ex_reg_wr_data_sel,
    input  logic                 i_ex_is_load,
    input  rv_pkg::reg_addr_t    i_mem_reg_wr_addr,
    input  logic                 i_mem_reg_wr_enable,
    input  logic                 i_mem_is_load,
    input  rv_pkg::reg_addr_t    i_wb_reg_wr_addr,
    input  logic                 i_wb_reg_wr_enable,
    output rv_pkg::fwd_sel_t     o_fwd_a_sel,
    output rv_pkg::fwd_sel_t     o_fwd_b_sel,
    output logic                 o_bubble   // Load-use stall request
);
    import rv_pkg::*;

    // Newest producer wins, x0 never forwards
    function automatic fwd_sel_t fwd_pick(input reg_addr_t rs);
        fwd_sel_t sel;
        if (rs == '0)
            sel = FWD_REG;
        else if (i_ex_reg_wr_enable && i_ex_reg_wr_addr == rs &&
                 i_ex_reg_wr_data_sel != WR_MEM)     // Load data not there yet
            sel = FWD_EX;
        else if (i_mem_reg_wr_enable && i_mem_reg_wr_addr == rs)
            sel = FWD_MEM;
        else if (i_wb_reg_wr_enable && i_wb_reg_wr_addr == rs)
            sel = FWD_WB;
        else
            sel = FWD_REG;
        return sel;
    endfunction

    // Source waits on a load still in EX or MEM
    function automatic logic load_hit(input reg_addr_t rs);
        return (rs != '0) &&
               ((i_ex_is_load && i_ex_reg_wr_addr == rs) ||
                (i_mem_is_load && i_mem_reg_wr_addr == rs));
    endfunction

    always_comb begin
        o_fwd_a_sel = fwd_pick(i_rs1);
        o_fwd_b_sel = fwd_pick(i_rs2);
        o_bubble    = load_hit(i_rs1) || load_hit(i_rs2);  // Fields tested even if unused
    end

endmodule

//--- source/inst_decoder.sv
module inst_decoder (
    input  rv_pkg::inst_t     i_inst,         // Fetched instruction
    output rv_pkg::op_code_t  o_op,           // Major opcode
    output logic [2:0]        o_funct3,
    output logic              o_funct7_bit5,  // SUB / SRA select
    output rv_pkg::reg_addr_t o_rs1,
    output rv_pkg::reg_addr_t o_rs2,
    output rv_pkg::reg_addr_t o_rd,
    output rv_pkg::data_t     o_imm,          // Sign extended immediate
    output logic              o_is_load,
    output logic              o_is_illegal
);
    import rv_pkg::*;

    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_u;
    data_t imm_j;

    // Fixed field positions, same for every format
    assign o_op          = op_code_t'(i_inst[6:0]);
    assign o_rd          = i_inst[11:7];
    assign o_funct3      = i_inst[14:12];
    assign o_rs1         = i_inst[19:15];
    assign o_rs2         = i_inst[24:20];
    assign o_funct7_bit5 = i_inst[30];

    // ---------------------------------------
    // Immediate formats
    // ---------------------------------------
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};                  // Offset in halfwords
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    always_comb begin
        o_imm        = '0;
        o_is_illegal = 1'b0;
        case (o_op)
            OP_LUI,
            OP_AUIPC:  o_imm = imm_u;
            OP_JAL:    o_imm = imm_j;
            OP_JALR,
            OP_LOAD,
            OP_IMM:    o_imm = imm_i;
            OP_BRANCH: o_imm = imm_b;
            OP_STORE:  o_imm = imm_s;
            OP_REG:    o_imm = '0;           // R type has no immediate
            // FENCE, SYSTEM, unknown opcodes, and low bits other than 11
            default:   o_is_illegal = 1'b1;
        endcase
    end

    assign o_is_load = (o_op == OP_LOAD);

endmodule

//--- source/register_file.sv
`include "rv_config.svh"

module register_file (
    input  logic              i_clock,
    input  logic              i_rst_n,
    input  logic              i_wr_enable,   // From WB
    input  rv_pkg::reg_addr_t i_wr_addr,
    input  rv_pkg::data_t     i_wr_data,
    input  rv_pkg::reg_addr_t i_rd_addr_a,   // rs1
    input  rv_pkg::reg_addr_t i_rd_addr_b,   // rs2
    output rv_pkg::data_t     o_rd_data_a,
    output rv_pkg::data_t     o_rd_data_b
);
    import rv_pkg::*;

    data_t regs [`RV_REG_COUNT];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (i_wr_enable && i_wr_addr != '0) begin  // x0 stays zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Asynchronous reads, same-cycle WB value comes through forwarding
    assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : regs[i_rd_addr_b];

endmodule

//--- source/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Core widths, RV32 only
`define RV_XLEN      32     // Data word width
`define RV_REG_COUNT 32     // Architectural registers x0..x31
`define RV_REG_AW    5      // Register number width

// addi x0, x0, 0
`define RV_NOP       32'h0000_0013

`endif

//--- source/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   data_t;
    typedef logic [31:0]           inst_t;
    typedef logic [31:0]           inst_addr_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } op_code_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, COPY_B
    } alu_op_t;

    typedef enum logic [1:0] {WR_ALU, WR_MEM, WR_PC4} wr_data_sel_t;   // rd write source
    typedef enum logic [1:0] {A_REG, A_PC, A_ZERO} operand_a_sel_t;
    typedef enum logic [1:0] {B_REG, B_IMM} operand_b_sel_t;
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JALR} pc_sel_t;
    typedef enum logic [1:0] {FWD_REG, FWD_EX, FWD_MEM, FWD_WB} fwd_sel_t;

endpackage

//--- source/stage_id.sv
module stage_id (
    input  logic                   i_clock,
    input  logic                   i_rst_n,
    input  rv_pkg::inst_t          i_inst,               // From IF
    input  rv_pkg::inst_addr_t     i_pc,
    input  rv_pkg::reg_addr_t      i_ex_reg_wr_addr,     // EX stage record
    input  logic                   i_ex_reg_wr_enable,
    input  rv_pkg::wr_data_sel_t   i_ex_reg_wr_data_sel,
    input  rv_pkg::data_t          i_ex_reg_wr_data,
    input  logic                   i_ex_is_load,
    input  rv_pkg::reg_addr_t      i_mem_reg_wr_addr,    // MEM stage record
    input  logic                   i_mem_reg_wr_enable,
    input  rv_pkg::data_t          i_mem_reg_wr_data,
    input  logic                   i_mem_is_load,
    input  rv_pkg::reg_addr_t      i_wb_reg_wr_addr,     // WB stage, also the RF write
    input  logic                   i_wb_reg_wr_enable,
    input  rv_pkg::data_t          i_wb_reg_wr_data,
    output rv_pkg::data_t          o_imm,
    output rv_pkg::data_t          o_data_a,             // Forwarded rs1
    output rv_pkg::data_t          o_data_b,             // Forwarded rs2
    output logic                   o_is_load,
    output logic                   o_is_illegal,
    output logic                   o_bubble,
    output rv_pkg::reg_addr_t      o_reg_wr_addr,        // rd
    output logic                   o_reg_wr_enable,
    output logic                   o_mem_wr_enable,
    output rv_pkg::wr_data_sel_t   o_reg_wr_data_sel,
    output rv_pkg::operand_a_sel_t o_operand_a_sel,
    output rv_pkg::operand_b_sel_t o_operand_b_sel,
    output rv_pkg::alu_op_t        o_alu_op,
    output rv_pkg::inst_addr_t     o_pc_next
);
    import rv_pkg::*;

    op_code_t   dec_op;
    logic [2:0] dec_funct3;
    logic       dec_funct7_bit5;
    reg_addr_t  dec_rs1;
    reg_addr_t  dec_rs2;
    pc_sel_t    ctrl_pc_sel;
    fwd_sel_t   fwd_a_sel;
    fwd_sel_t   fwd_b_sel;
    data_t      rf_data_a;
    data_t      rf_data_b;
    logic       br_equal;
    logic       br_less_signed;
    logic       br_less_unsigned;

    // ---------------------------------------
    // Decode and control
    // ---------------------------------------
    inst_decoder dec_i (
        .i_inst        (i_inst),
        .o_op          (dec_op),
        .o_funct3      (dec_funct3),
        .o_funct7_bit5 (dec_funct7_bit5),
        .o_rs1         (dec_rs1),
        .o_rs2         (dec_rs2),
        .o_rd          (o_reg_wr_addr),
        .o_imm         (o_imm),
        .o_is_load     (o_is_load),
        .o_is_illegal  (o_is_illegal)
    );

    datapath_controller ctrl_i (
        .i_op              (dec_op),
        .i_funct3          (dec_funct3),
        .i_funct7_bit5     (dec_funct7_bit5),
        .i_is_illegal      (o_is_illegal),      // Kills both write enables
        .i_equal           (br_equal),
        .i_less_signed     (br_less_signed),
        .i_less_unsigned   (br_less_unsigned),
        .o_reg_wr_enable   (o_reg_wr_enable),
        .o_mem_wr_enable   (o_mem_wr_enable),
        .o_reg_wr_data_sel (o_reg_wr_data_sel),
        .o_operand_a_sel   (o_operand_a_sel),
        .o_operand_b_sel   (o_operand_b_sel),
        .o_alu_op          (o_alu_op),
        .o_pc_sel          (ctrl_pc_sel)
    );

    hazard_unit haz_i (
        .i_rs1                (dec_rs1),
        .i_rs2                (dec_rs2),
        .i_ex_reg_wr_addr     (i_ex_reg_wr_addr),
        .i_ex_reg_wr_enable   (i_ex_reg_wr_enable),
        .i_ex_reg_wr_data_sel (i_ex_reg_wr_data_sel),
        .i_ex_is_load         (i_ex_is_load),
        .i_mem_reg_wr_addr    (i_mem_reg_wr_addr),
        .i_mem_reg_wr_enable  (i_mem_reg_wr_enable),
        .i_mem_is_load        (i_mem_is_load),
        .i_wb_reg_wr_addr     (i_wb_reg_wr_addr),
        .i_wb_reg_wr_enable   (i_wb_reg_wr_enable),
        .o_fwd_a_sel          (fwd_a_sel),
        .o_fwd_b_sel          (fwd_b_sel),
        .o_bubble             (o_bubble)        // Pipeline inserts the NOP
    );

    // ---------------------------------------
    // Operands
    // ---------------------------------------
    register_file rf_i (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_wr_enable (i_wb_reg_wr_enable),
        .i_wr_addr   (i_wb_reg_wr_addr),
        .i_wr_data   (i_wb_reg_wr_data),
        .i_rd_addr_a (dec_rs1),
        .i_rd_addr_b (dec_rs2),
        .o_rd_data_a (rf_data_a),
        .o_rd_data_b (rf_data_b)
    );

    // 4 to 1 forwarding mux, shared by both operands
    function automatic data_t fwd_mux(input fwd_sel_t sel, input data_t reg_data);
        data_t val;
        case (sel)
            FWD_EX:  val = i_ex_reg_wr_data;
            FWD_MEM: val = i_mem_reg_wr_data;
            FWD_WB:  val = i_wb_reg_wr_data;
            default: val = reg_data;
        endcase
        return val;
    endfunction

    always_comb begin
        o_data_a = fwd_mux(fwd_a_sel, rf_data_a);
        o_data_b = fwd_mux(fwd_b_sel, rf_data_b);
    end

    // Branches resolve here on forwarded data
    branch_unit br_i (
        .i_data_a        (o_data_a),
        .i_data_b        (o_data_b),
        .i_pc            (i_pc),
        .i_imm           (o_imm),
        .i_pc_sel        (ctrl_pc_sel),
        .o_equal         (br_equal),
        .o_less_signed   (br_less_signed),
        .o_less_unsigned (br_less_unsigned),
        .o_pc_next       (o_pc_next)
    );

endmodule

//--- testbench/stage_id_tb.sv
module stage_id_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_TESTS   = 3000;
    localparam int TEST_CYCLES = 4 + 32 + NUM_TESTS;  // Reset, zero sweep, random

    logic           i_clock;
    logic           i_rst_n;
    inst_t          i_inst;
    inst_addr_t     i_pc;
    reg_addr_t      i_ex_reg_wr_addr;
    logic           i_ex_reg_wr_enable;
    wr_data_sel_t   i_ex_reg_wr_data_sel;
    data_t          i_ex_reg_wr_data;
    logic           i_ex_is_load;
    reg_addr_t      i_mem_reg_wr_addr;
    logic           i_mem_reg_wr_enable;
    data_t          i_mem_reg_wr_data;
    logic           i_mem_is_load;
    reg_addr_t      i_wb_reg_wr_addr;
    logic           i_wb_reg_wr_enable;
    data_t          i_wb_reg_wr_data;
    data_t          o_imm;
    data_t          o_data_a;
    data_t          o_data_b;
    logic           o_is_load;
    logic           o_is_illegal;
    logic           o_bubble;
    reg_addr_t      o_reg_wr_addr;
    logic           o_reg_wr_enable;
    logic           o_mem_wr_enable;
    wr_data_sel_t   o_reg_wr_data_sel;
    operand_a_sel_t o_operand_a_sel;
    operand_b_sel_t o_operand_b_sel;
    alu_op_t        o_alu_op;
    inst_addr_t     o_pc_next;

    logic [31:0] lfsr = 32'hf9a3397f;
    logic [31:0] model_regs [32];   // Reference register state
    int          checks = 0;
    int          errors = 0;

    stage_id dut_i (.*);

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    // ----------------------------------------
    // Random source and compare
    // ----------------------------------------
    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Frequent small values so compares hit equal
    function automatic logic [31:0] rand_data();
        if (rand_bits(2) == 0)
            return rand_bits(2);
        return rand_bits(32);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Newest producer first with EX skipped while its data comes from memory
    function automatic logic [31:0] fwd_value(input logic [4:0] rs);
        if (rs == 5'd0)
            return 32'd0;
        if (i_ex_reg_wr_enable && i_ex_reg_wr_addr == rs && i_ex_reg_wr_data_sel != WR_MEM)
            return i_ex_reg_wr_data;
        if (i_mem_reg_wr_enable && i_mem_reg_wr_addr == rs)
            return i_mem_reg_wr_data;
        if (i_wb_reg_wr_enable && i_wb_reg_wr_addr == rs)
            return i_wb_reg_wr_data;
        return model_regs[rs];
    endfunction

    function automatic logic load_use(input logic [4:0] rs);
        return rs != 5'd0 && ((i_ex_is_load && i_ex_reg_wr_addr == rs) ||
                              (i_mem_is_load && i_mem_reg_wr_addr == rs));
    endfunction

    function automatic alu_op_t alu_expected(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
        case (f3)
            3'd0:    return (alt && is_reg) ? SUB : ADD;  // No SUBI
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return alt ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;                    // BEQ
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);   // BLT
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;                     // BLTU
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_outputs();
        logic [31:0]    inst;
        logic [31:0]    imm_i;
        logic [31:0]    imm_s;
        logic [31:0]    exp_imm;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    exp_pc;
        logic           legal;
        logic           reg_we;
        logic           mem_we;
        wr_data_sel_t   wsel;
        operand_a_sel_t asel;
        operand_b_sel_t bsel;
        alu_op_t        alu;
        inst   = i_inst;
        imm_i  = 32'($signed(inst) >>> 20);
        imm_s  = (imm_i & ~32'h1f) | {27'd0, inst[11:7]};
        a      = fwd_value(inst[19:15]);
        b      = fwd_value(inst[24:20]);
        legal  = 1'b1;
        reg_we = 1'b1;
        mem_we = 1'b0;
        wsel   = WR_ALU;
        asel   = A_REG;
        bsel   = B_REG;
        alu    = ADD;
        exp_imm = 32'd0;
        exp_pc  = i_pc + 32'd4;
        case (inst[6:0])
            OP_LUI: begin
                exp_imm = inst & 32'hffff_f000;
                asel    = A_ZERO;
                bsel    = B_IMM;
            end
            OP_AUIPC: begin
                exp_imm = inst & 32'hffff_f000;
                asel    = A_PC;
                bsel    = B_IMM;
            end
            OP_JAL: begin
                // J format rebuilt from the I immediate
                exp_imm = (imm_i & 32'hfff0_07fe) | (inst & 32'h000f_f000) |
                          {20'd0, inst[20], 11'd0};
                wsel    = WR_PC4;
                exp_pc  = i_pc + exp_imm;
            end
            OP_JALR: begin
                exp_imm = imm_i;
                wsel    = WR_PC4;
                exp_pc  = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                exp_imm = (imm_s & ~32'h801) | {20'd0, inst[7], 11'd0};  // B from S
                reg_we  = 1'b0;
                if (branch_taken(inst[14:12], a, b))
                    exp_pc = i_pc + exp_imm;
            end
            OP_LOAD: begin
                exp_imm = imm_i;
                wsel    = WR_MEM;
                bsel    = B_IMM;
            end
            OP_STORE: begin
                exp_imm = imm_s;
                reg_we  = 1'b0;
                mem_we  = 1'b1;
                bsel    = B_IMM;
            end
            OP_IMM: begin
                exp_imm = imm_i;
                bsel    = B_IMM;
                alu     = alu_expected(inst[14:12], inst[30], 1'b0);
            end
            OP_REG:    alu = alu_expected(inst[14:12], inst[30], 1'b1);
            default: begin
                legal  = 1'b0;  // FENCE, SYSTEM and unknown
                reg_we = 1'b0;
            end
        endcase
        check_value("o_is_illegal", 32'(!legal), 32'(o_is_illegal));
        check_value("o_reg_wr_addr", 32'(inst[11:7]), 32'(o_reg_wr_addr));
        check_value("o_data_a", a, o_data_a);
        check_value("o_data_b", b, o_data_b);
        check_value("o_bubble", 32'(load_use(inst[19:15]) || load_use(inst[24:20])),
                    32'(o_bubble));
        check_value("o_reg_wr_enable", 32'(reg_we), 32'(o_reg_wr_enable));
        check_value("o_mem_wr_enable", 32'(mem_we), 32'(o_mem_wr_enable));
        check_value("o_is_load", 32'(inst[6:0] == OP_LOAD), 32'(o_is_load));
        check_value("o_pc_next", exp_pc, o_pc_next);
        if (legal) begin
            check_value("o_imm", exp_imm, o_imm);
            check_value("o_reg_wr_data_sel", 32'(wsel), 32'(o_reg_wr_data_sel));
            check_value("o_operand_a_sel", 32'(asel), 32'(o_operand_a_sel));
            check_value("o_operand_b_sel", 32'(bsel), 32'(o_operand_b_sel));
            check_value("o_alu_op", 32'(alu), 32'(o_alu_op));
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic drive_random();
        int          cls;
        logic [31:0] inst;
        logic [31:0] r;
        logic [2:0]  f3;
        logic        b5;
        cls  = int'(rand_bits(4) % 11);
        inst = rand_bits(32);
        f3   = 3'(rand_bits(3));
        b5   = rand_bits(1) != 0;
        case (cls)
            0: inst[6:0] = OP_LUI;
            1: inst[6:0] = OP_AUIPC;
            2: inst[6:0] = OP_JAL;
            3: begin
                inst[6:0] = OP_JALR;
                f3        = 3'd0;
            end
            4: begin
                inst[6:0] = OP_BRANCH;
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;  // Avoid reserved funct3
            end
            5: inst[6:0] = OP_LOAD;
            6: inst[6:0] = OP_STORE;
            7: begin
                inst[6:0] = OP_IMM;
                if (f3 == 3'd1)
                    inst[31:25] = 7'd0;
                if (f3 == 3'd5)
                    inst[31:25] = {1'b0, b5, 5'd0};  // SRAI or SRLI
            end
            8: begin
                inst[6:0]   = OP_REG;
                inst[31:25] = {1'b0, b5 && (f3 == 3'd0 || f3 == 3'd5), 5'd0};
            end
            9: begin
                r = rand_bits(2) % 3;                 // Low bits never 11
                inst[1:0] = r[1:0];
            end
            default: inst[6:0] = rand_bits(1) != 0 ? OP_FENCE : OP_SYSTEM;
        endcase
        // Narrow register range so addresses collide
        if (cls > 2) begin
            inst[14:12] = f3;
            inst[19:15] = 5'(rand_bits(3));
            inst[24:20] = 5'(rand_bits(3));
        end
        i_inst               = inst;
        i_pc                 = {rand_bits(30), 2'b00};
        i_ex_reg_wr_addr     = 5'(rand_bits(3));
        i_ex_reg_wr_enable   = rand_bits(1) != 0;
        i_ex_reg_wr_data_sel = wr_data_sel_t'(2'(rand_bits(2) % 3));
        i_ex_reg_wr_data     = rand_data();
        i_ex_is_load         = rand_bits(2) == 0;
        i_mem_reg_wr_addr    = 5'(rand_bits(3));
        i_mem_reg_wr_enable  = rand_bits(1) != 0;
        i_mem_reg_wr_data    = rand_data();
        i_mem_is_load        = rand_bits(2) == 0;
        i_wb_reg_wr_addr     = 5'(rand_bits(3));
        i_wb_reg_wr_enable   = rand_bits(1) != 0;
        i_wb_reg_wr_data     = rand_data();
    endtask

    // Watchdog at twice the expected run length
    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 2);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'd0;
        i_rst_n              = 1'b0;
        i_inst               = '0;
        i_pc                 = '0;
        i_ex_reg_wr_addr     = '0;
        i_ex_reg_wr_enable   = 1'b0;
        i_ex_reg_wr_data_sel = WR_ALU;
        i_ex_reg_wr_data     = '0;
        i_ex_is_load         = 1'b0;
        i_mem_reg_wr_addr    = '0;
        i_mem_reg_wr_enable  = 1'b0;
        i_mem_reg_wr_data    = '0;
        i_mem_is_load        = 1'b0;
        i_wb_reg_wr_addr     = '0;
        i_wb_reg_wr_enable   = 1'b0;
        i_wb_reg_wr_data     = '0;
        repeat (3) @(posedge i_clock);
        #3;
        // Zero instruction in reset must not write
        check_value("o_is_illegal", 32'd1, 32'(o_is_illegal));
        check_value("o_reg_wr_enable", 32'd0, 32'(o_reg_wr_enable));
        check_value("o_mem_wr_enable", 32'd0, 32'(o_mem_wr_enable));
        @(posedge i_clock);
        #1 i_rst_n = 1'b1;

        // Every register reads zero after reset
        for (int r = 0; r < 32; r++) begin
            @(posedge i_clock);
            #1 i_inst = {7'd0, 5'(r), 5'(31 - r), 3'd0, 5'd1, OP_REG};
            #2.5;
            check_value("o_data_a", 32'd0, o_data_a);
            check_value("o_data_b", 32'd0, o_data_b);
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge i_clock);
            #1 drive_random();
            #2.5;
            check_outputs();
            if (i_wb_reg_wr_enable && i_wb_reg_wr_addr != 5'd0)
                model_regs[i_wb_reg_wr_addr] = i_wb_reg_wr_data;  // Lands on next edge
        end

        $display("Finished %0d checks with %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
